// File: Bender.yml
package:
  name: sd_word_reader

sources:
  # Design
  - files:
      - rtl/sdReadPkg.sv
      - rtl/reqDispatch.sv
      - rtl/sectorFetch.sv
      - rtl/wordCatch.sv
      - rtl/respCollect.sv
      - rtl/sdWordReader.sv

  # Verification
  - target: test
    files:
      - dv/sdWordReader_chk.sv
      - dv/sdWordReaderTb.sv

# Testbench top: sdWordReaderTb
# Design top: sdWordReader
# Flat file list: build.f

// File: build.f
rtl/sdReadPkg.sv
rtl/reqDispatch.sv
rtl/sectorFetch.sv
rtl/wordCatch.sv
rtl/respCollect.sv
rtl/sdWordReader.sv
dv/sdWordReader_chk.sv
dv/sdWordReaderTb.sv

// File: dv/sdWordReaderTb.sv
`timescale 1ns/1ps

module sdWordReaderTb;

    localparam int     ClockPeriod  = 8;
    localparam int     NumReqs      = 200;
    localparam int     HoldCycles   = 500;
    localparam int     HoldAfter    = 60;     // Responses seen before credits are withheld
    localparam int     SectorCycles = 1100;   // Worst card pass with gaps and start delay
    localparam longint TimeoutNs    =
        (longint'(NumReqs) * 3 * SectorCycles + HoldCycles + 5000) * ClockPeriod;

    logic                 Clock;
    logic                 rstN;
    logic                 reqValid;
    sdReadPkg::wordAddr_t reqAddr;
    logic                 reqCredit;
    logic                 respValid;
    logic [31:0]          respData;
    logic                 respCredit;
    logic                 cardReady;
    logic                 cardRdReq;
    logic [31:0]          cardAddr;
    logic                 cardByteValid;
    logic [7:0]           cardByte;

    logic [31:0] expQ [$];   // Request addresses in issue order
    int          respCount;

    sdWordReader uut (
        .Clock         (Clock),
        .rstN          (rstN),
        .reqValid      (reqValid),
        .reqAddr       (reqAddr),
        .reqCredit     (reqCredit),
        .respValid     (respValid),
        .respData      (respData),
        .respCredit    (respCredit),
        .cardReady     (cardReady),
        .cardRdReq     (cardRdReq),
        .cardAddr      (cardAddr),
        .cardByteValid (cardByteValid),
        .cardByte      (cardByte)
    );

    bind sdWordReader sdWordReader_chk chk (
        .Clock      (Clock),
        .rstN       (rstN),
        .reqValid   (reqValid),
        .reqCredit  (reqCredit),
        .respValid  (respValid),
        .respCredit (respCredit),
        .cardReady  (cardReady),
        .cardRdReq  (cardRdReq),
        .busValid   (sectorBus.valid),
        .busLast    (sectorBus.last)
    );

    always #(ClockPeriod / 2) Clock = ~Clock;

    // Card content at an absolute byte address
    function automatic logic [7:0] cardData(input logic [31:0] a);
        return 8'((a * 37) + 11);
    endfunction

    // Sector and word index together give the byte address divided by 4
    function automatic logic [31:0] expectedWord(input logic [31:0] addr);
        logic [31:0] base;
        base = {9'b0, addr[20:0], 2'b00};
        return {cardData(base), cardData(base + 1), cardData(base + 2), cardData(base + 3)};
    endfunction

    task automatic checkEqual(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s got %h expected %h", $time, what, got, exp);
            $display("Done: errors found");
            $fatal(1, "Stopping at first mismatch");
        end
    endtask

    task automatic serveCard();
        logic [31:0] base;
        @(posedge rstN);
        repeat ($urandom_range(5, 20)) @(posedge Clock);
        cardReady <= 1'b1;
        forever begin
            @(posedge Clock);
            if (cardRdReq) begin
                base = cardAddr;
                repeat ($urandom_range(3, 10)) @(posedge Clock);
                for (int b = 0; b < sdReadPkg::SectorBytes; b++) begin
                    while ($urandom_range(0, 3) == 0) begin   // Random gap
                        cardByteValid <= 1'b0;
                        @(posedge Clock);
                    end
                    cardByteValid <= 1'b1;
                    cardByte      <= cardData(base + b);
                    @(posedge Clock);
                end
                cardByteValid <= 1'b0;
                while (cardRdReq) @(posedge Clock);   // Request drops after the last byte
            end
        end
    endtask

    task automatic sendRequests();
        int          credits;
        int          sent;
        int          pick;
        logic [13:0] sector;
        logic [6:0]  wordIdx;
        logic [13:0] recent [4];
        logic [31:0] addr;
        credits = sdReadPkg::ReqDepth;
        sent    = 0;
        foreach (recent[i]) recent[i] = 14'(i);
        wait (cardReady);
        while (sent < NumReqs) begin
            @(posedge Clock);
            reqValid <= 1'b0;
            if (reqCredit) credits++;
            if (credits > 0 && $urandom_range(0, 2) != 0) begin
                if ($urandom_range(0, 2) == 0) sector = recent[$urandom_range(0, 3)];
                else sector = 14'($urandom_range(0, 15));   // Small range so lanes share passes
                recent[sent % 4] = sector;
                pick = (sent < 2) ? sent : $urandom_range(0, 9);
                wordIdx = (pick == 0) ? 7'd0 : (pick == 1) ? 7'd127 : 7'($urandom);
                addr = {11'($urandom), sector, wordIdx};   // High bits are ignored
                reqValid    <= 1'b1;
                reqAddr.raw <= addr;
                expQ.push_back(addr);
                credits--;
                sent++;
            end
        end
        @(posedge Clock);
        reqValid <= 1'b0;
    endtask

    task automatic takeResponses();
        int          owed;
        int          holdLeft;
        bit          held;
        logic [31:0] addr;
        owed     = 0;
        holdLeft = 0;
        held     = 1'b0;
        forever begin
            @(posedge Clock);
            respCredit <= 1'b0;
            if (respValid) begin
                if (expQ.size() == 0) begin
                    $display("A response arrived with no request outstanding");
                    $display("Done: errors found");
                    $fatal(1, "Extra response");
                end
                addr = expQ.pop_front();
                checkEqual(respData, expectedWord(addr),
                           $sformatf("response %0d for address %h", respCount, addr));
                respCount++;
                owed++;
            end
            if (!held && respCount >= HoldAfter) begin
                held     = 1'b1;
                holdLeft = HoldCycles;   // Starve the collector for a while
            end else if (holdLeft > 0) begin
                holdLeft--;
            end else if (owed > 0 && $urandom_range(0, 3) == 0) begin
                respCredit <= 1'b1;
                owed--;
            end
        end
    endtask

    initial begin
        void'($urandom(8030));
        Clock         = 1'b0;
        rstN          = 1'b0;
        reqValid      = 1'b0;
        reqAddr       = '0;
        respCredit    = 1'b0;
        cardReady     = 1'b0;
        cardByteValid = 1'b0;
        cardByte      = '0;
        respCount     = 0;
        fork
            serveCard();
            sendRequests();
            takeResponses();
        join_none
        repeat (3) @(posedge Clock);
        rstN <= 1'b1;
        wait (respCount == NumReqs);
        repeat (100) @(posedge Clock);   // Room for any stray response
        if (uut.chk.failCount == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            $display("Done: errors found");
            $fatal(1, "Checker assertion failed");
        end
    end

    initial begin
        wait (uut.chk.failCount != 0);
        $display("A credit or card-handshake assertion failed in the checker");
        $display("Done: errors found");
        $fatal(1, "Assertion failure");
    end

    initial begin
        #(TimeoutNs);
        $display("Watchdog expired: the run timed out before all responses arrived");
        $display("Done: errors found");
        $fatal(1, "Timeout");
    end

endmodule

// File: dv/sdWordReader_chk.sv
`timescale 1ns/1ps

module sdWordReader_chk (
    input logic Clock,
    input logic rstN,
    input logic reqValid,
    input logic reqCredit,
    input logic respValid,
    input logic respCredit,
    input logic cardReady,
    input logic cardRdReq,
    input logic busValid,
    input logic busLast
);

    logic [15:0] accepted;    // Requests pushed so far
    logic [15:0] returned;    // Request credits handed back
    logic [15:0] respSeen;
    logic [15:0] creditsIn;   // Consumer credit returns
    int          failCount = 0;

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            accepted  <= '0;
            returned  <= '0;
            respSeen  <= '0;
            creditsIn <= '0;
        end else begin
            accepted  <= accepted + reqValid;
            returned  <= returned + reqCredit;
            respSeen  <= respSeen + respValid;
            creditsIn <= creditsIn + respCredit;
        end
    end

    assert property (@(posedge Clock) disable iff (!rstN) reqCredit |-> accepted > returned)
        else begin
            $error("reqCredit pulsed with no accepted request left");
            failCount++;
        end

    assert property (@(posedge Clock) disable iff (!rstN)
        respValid |-> respSeen < creditsIn + 16'(sdReadPkg::RespCredits))
        else begin
            $error("respValid fired without a consumer credit");
            failCount++;
        end

    // Quiet until the card has finished init
    assert property (@(posedge Clock) disable iff (!rstN)
        !cardReady |-> !cardRdReq && !respValid && !reqCredit)
        else begin
            $error("Activity before cardReady");
            failCount++;
        end

    assert property (@(posedge Clock) disable iff (!rstN)
        $fell(cardRdReq) |-> $past(busValid && busLast))
        else begin
            $error("cardRdReq fell before byte 511 was broadcast");
            failCount++;
        end

endmodule

// File: rtl/reqDispatch.sv
`timescale 1ns/1ps

module reqDispatch (
    input  logic                           Clock,
    input  logic                           rstN,
    input  logic                           reqValid,
    input  sdReadPkg::wordAddr_t           reqAddr,
    output logic                           reqCredit,
    input  sdReadPkg::laneStat_t           laneStat [sdReadPkg::NumLanes],
    output logic [sdReadPkg::NumLanes-1:0] laneLoad,
    output sdReadPkg::wordAddr_t           loadAddr
);

    localparam int PtrBits = $clog2(sdReadPkg::ReqDepth);

    sdReadPkg::wordAddr_t fifoMem [sdReadPkg::ReqDepth];
    logic [PtrBits-1:0]   wrPtr;
    logic [PtrBits-1:0]   rdPtr;
    logic [PtrBits:0]     count;
    sdReadPkg::laneIdx_t  nextLane;
    logic                 pop;

    // Lanes are filled strictly in turn so lane order is request order
    assign pop = (count != '0) && !laneStat[nextLane].pending;

    assign reqCredit = pop;   // One credit back per pop
    assign loadAddr  = fifoMem[rdPtr];

    always_comb begin
        laneLoad = '0;
        laneLoad[nextLane] = pop;
    end

    // No full check here, client credits keep the FIFO from overflowing
    always_ff @(posedge Clock) begin
        if (reqValid) begin
            fifoMem[wrPtr] <= reqAddr;
        end
    end

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            wrPtr    <= '0;
            rdPtr    <= '0;
            count    <= '0;
            nextLane <= '0;
        end else begin
            if (reqValid) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr    <= rdPtr + 1'b1;
                nextLane <= nextLane + 1'b1;   // Wraps at NumLanes
            end
            case ({reqValid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;       // Idle or push and pop together
            endcase
        end
    end

endmodule

// File: rtl/respCollect.sv
`timescale 1ns/1ps

module respCollect (
    input  logic                           Clock,
    input  logic                           rstN,
    input  sdReadPkg::laneStat_t           laneStat [sdReadPkg::NumLanes],
    input  logic [31:0]                    laneWord [sdReadPkg::NumLanes],
    output logic [sdReadPkg::NumLanes-1:0] laneRelease,
    output logic                           respValid,
    output logic [31:0]                    respData,
    input  logic                           respCredit
);

    localparam int CreditBits = $clog2(sdReadPkg::RespCredits + 1);

    sdReadPkg::laneIdx_t   head;
    logic [CreditBits-1:0] credits;
    logic                  fire;

    // Only the head lane may answer, which keeps request order
    assign fire = laneStat[head].done && (credits != '0);

    always_ff @(posedge Clock) begin
        if (fire) begin
            respData <= laneWord[head];
        end
    end

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            head        <= '0;
            credits     <= CreditBits'(sdReadPkg::RespCredits);
            respValid   <= 1'b0;
            laneRelease <= '0;
        end else begin
            respValid   <= fire;
            laneRelease <= '0;
            if (fire) begin
                laneRelease[head] <= 1'b1;   // Same cycle as respValid
                head              <= head + 1'b1;
            end
            // Consumer return and our spend may land together
            case ({respCredit, fire})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

// File: rtl/sdReadPkg.sv
package sdReadPkg;

    // Lane and credit sizing
    localparam int NumLanes    = 4;   // Power of two, 2 to 8
    localparam int ReqDepth    = 4;   // Also the client's initial request credits
    localparam int RespCredits = 2;

    // Sector geometry
    localparam int SectorBytes = 512;
    localparam int ByteBits    = $clog2(SectorBytes);
    localparam int SectorBits  = 14;
    localparam int WordBits    = 7;
    localparam int LaneBits    = $clog2(NumLanes);

    typedef logic [LaneBits-1:0] laneIdx_t;

    // Word address split into sector and word within the sector
    typedef struct packed {
        logic [31-SectorBits-WordBits:0] unused;
        logic [SectorBits-1:0]           sector;
        logic [WordBits-1:0]             word;
    } addrFields_t;

    // Client stores the raw word, lanes read the decoded fields
    typedef union packed {
        logic [31:0] raw;
        addrFields_t dec;
    } wordAddr_t;

    // One numbered byte of the sector being streamed
    typedef struct packed {
        logic                  valid;
        logic [SectorBits-1:0] sector;
        logic [ByteBits-1:0]   index;
        logic [7:0]            data;
        logic                  last;   // Set on byte 511
    } sectorByte_t;

    typedef struct packed {
        logic pending;
        logic done;
    } laneStat_t;

endpackage

// File: rtl/sdWordReader.sv
`timescale 1ns/1ps

module sdWordReader (
    input  logic                 Clock,
    input  logic                 rstN,
    // Client requests
    input  logic                 reqValid,
    input  sdReadPkg::wordAddr_t reqAddr,
    output logic                 reqCredit,
    // Consumer responses
    output logic                 respValid,
    output logic [31:0]          respData,
    input  logic                 respCredit,
    // Card byte stream
    input  logic                 cardReady,
    output logic                 cardRdReq,
    output logic [31:0]          cardAddr,
    input  logic                 cardByteValid,
    input  logic [7:0]           cardByte
);

    sdReadPkg::laneStat_t             laneStat [sdReadPkg::NumLanes];
    logic [sdReadPkg::SectorBits-1:0] laneSector [sdReadPkg::NumLanes];
    logic [31:0]                      laneWord [sdReadPkg::NumLanes];
    logic [sdReadPkg::NumLanes-1:0]   laneLoad;
    logic [sdReadPkg::NumLanes-1:0]   laneRelease;
    sdReadPkg::wordAddr_t             loadAddr;
    sdReadPkg::sectorByte_t           sectorBus;   // Shared by all lanes

    reqDispatch dispatch (
        .Clock     (Clock),
        .rstN      (rstN),
        .reqValid  (reqValid),
        .reqAddr   (reqAddr),
        .reqCredit (reqCredit),
        .laneStat  (laneStat),
        .laneLoad  (laneLoad),
        .loadAddr  (loadAddr)
    );

    sectorFetch fetch (
        .Clock         (Clock),
        .rstN          (rstN),
        .cardReady     (cardReady),
        .cardRdReq     (cardRdReq),
        .cardAddr      (cardAddr),
        .cardByteValid (cardByteValid),
        .cardByte      (cardByte),
        .laneStat      (laneStat),
        .laneSector    (laneSector),
        .sectorBus     (sectorBus)
    );

    for (genvar i = 0; i < sdReadPkg::NumLanes; i++) begin : gLane
        wordCatch lane (
            .Clock       (Clock),
            .rstN        (rstN),
            .load        (laneLoad[i]),
            .loadAddr    (loadAddr),
            .releaseLane (laneRelease[i]),
            .sectorBus   (sectorBus),
            .stat        (laneStat[i]),
            .sector      (laneSector[i]),
            .word        (laneWord[i])
        );
    end

    respCollect collect (
        .Clock       (Clock),
        .rstN        (rstN),
        .laneStat    (laneStat),
        .laneWord    (laneWord),
        .laneRelease (laneRelease),
        .respValid   (respValid),
        .respData    (respData),
        .respCredit  (respCredit)
    );

endmodule

// File: rtl/sectorFetch.sv
`timescale 1ns/1ps

module sectorFetch (
    input  logic                                Clock,
    input  logic                                rstN,
    input  logic                                cardReady,
    output logic                                cardRdReq,
    output logic [31:0]                         cardAddr,
    input  logic                                cardByteValid,
    input  logic [7:0]                          cardByte,
    input  sdReadPkg::laneStat_t                laneStat [sdReadPkg::NumLanes],
    input  logic [sdReadPkg::SectorBits-1:0]    laneSector [sdReadPkg::NumLanes],
    output sdReadPkg::sectorByte_t              sectorBus
);

    typedef enum logic [1:0] {
        WaitCard,
        Idle,
        Stream
    } state_t;

    state_t                           state;
    logic [sdReadPkg::SectorBits-1:0] curSector;
    logic [sdReadPkg::ByteBits-1:0]   byteCnt;
    logic                             pickValid;
    logic [sdReadPkg::SectorBits-1:0] pickSector;

    // Lowest-index lane still waiting wins
    always_comb begin
        pickValid  = 1'b0;
        pickSector = laneSector[0];
        for (int i = sdReadPkg::NumLanes - 1; i >= 0; i--) begin
            if (laneStat[i].pending && !laneStat[i].done) begin
                pickValid  = 1'b1;
                pickSector = laneSector[i];
            end
        end
    end

    // Byte address of the sector start
    assign cardAddr = 32'(curSector) << sdReadPkg::ByteBits;

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            state     <= WaitCard;
            cardRdReq <= 1'b0;
            curSector <= '0;
            byteCnt   <= '0;
            sectorBus <= '0;
        end else begin
            sectorBus.valid <= 1'b0;
            case (state)
                WaitCard: begin
                    if (cardReady) state <= Idle;   // Card init finished
                end
                Idle: begin
                    if (cardReady && pickValid) begin
                        curSector <= pickSector;
                        byteCnt   <= '0;
                        cardRdReq <= 1'b1;
                        state     <= Stream;
                    end
                end
                Stream: begin
                    if (cardByteValid) begin
                        sectorBus.valid  <= 1'b1;
                        sectorBus.sector <= curSector;
                        sectorBus.index  <= byteCnt;
                        sectorBus.data   <= cardByte;
                        sectorBus.last   <= byteCnt == sdReadPkg::ByteBits'(sdReadPkg::SectorBytes - 1);
                        byteCnt          <= byteCnt + 1'b1;
                    end
                    // Drop the request once byte 511 is on the bus
                    if (sectorBus.valid && sectorBus.last) begin
                        cardRdReq <= 1'b0;
                        state     <= Idle;
                    end
                end
                default: state <= WaitCard;
            endcase
        end
    end

endmodule

// File: rtl/wordCatch.sv
`timescale 1ns/1ps

module wordCatch (
    input  logic                             Clock,
    input  logic                             rstN,
    input  logic                             load,
    input  sdReadPkg::wordAddr_t             loadAddr,
    input  logic                             releaseLane,
    input  sdReadPkg::sectorByte_t           sectorBus,
    output sdReadPkg::laneStat_t             stat,
    output logic [sdReadPkg::SectorBits-1:0] sector,
    output logic [31:0]                      word
);

    sdReadPkg::wordAddr_t addr;
    logic                 pending;
    logic                 done;
    logic [1:0]           hits;
    logic                 hit;

    // Byte belongs to this lane when sector and word slot match
    assign hit = pending && !done && sectorBus.valid
               && (sectorBus.sector == addr.dec.sector)
               && (sectorBus.index[sdReadPkg::ByteBits-1:2] == addr.dec.word);

    assign stat   = '{pending: pending, done: done};
    assign sector = addr.dec.sector;

    always_ff @(posedge Clock) begin
        if (load) begin
            addr <= loadAddr;
        end
        if (hit) begin
            // Most significant byte first within the word
            case (sectorBus.index[1:0])
                2'd0:    word[31:24] <= sectorBus.data;
                2'd1:    word[23:16] <= sectorBus.data;
                2'd2:    word[15:8]  <= sectorBus.data;
                default: word[7:0]   <= sectorBus.data;
            endcase
        end
    end

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            pending <= 1'b0;
            done    <= 1'b0;
            hits    <= '0;
        end else if (releaseLane) begin
            pending <= 1'b0;
            done    <= 1'b0;
            hits    <= '0;
        end else begin
            if (load) begin
                pending <= 1'b1;
                hits    <= '0;
            end
            if (hit) begin
                hits <= hits + 1'b1;
                if (hits == 2'd3) done <= 1'b1;   // Fourth byte in
            end
        end
    end

endmodule
